/* logic/claw_pkg.sv */
package claw_pkg;

    //////////////////////////////
    // Bus types
    //////////////////////////////

    // Wishbone classic request, held by the master until ack
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [1:0] adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // Register map
    localparam logic [1:0] REG_CMD    = 2'd0;
    localparam logic [1:0] REG_MOTION = 2'd1;
    localparam logic [1:0] REG_ANGLE  = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3; // Read only

    //////////////////////////////
    // Commands and letters
    //////////////////////////////

    typedef enum logic [1:0] {
        CMD_IDLE  = 2'd0,
        CMD_TRACE = 2'd1,
        CMD_GET   = 2'd2,
        CMD_WRITE = 2'd3
    } cmd_e;

    typedef enum logic [2:0] {
        LTR_A = 3'd0,
        LTR_B = 3'd1,
        LTR_D = 3'd2,
        LTR_N = 3'd3,
        LTR_V = 3'd4,
        LTR_S = 3'd5,
        LTR_X = 3'd6,
        LTR_Z = 3'd7
    } letter_e;

    // Register side view of the motion logic
    typedef struct packed {
        logic       start;  // One cycle, on a command write
        cmd_e       cmd;
        letter_e    letter;
        logic       dir_x;
        logic       dir_y;
        logic       enable;
        logic [2:0] angle;
    } motion_ctrl_t;

    typedef struct packed {
        logic slow_x;
        logic slow_y;
    } axis_rate_t;

    //////////////////////////////
    // Letter profiles
    //////////////////////////////

    localparam int SEG_COUNT = 8;
    localparam int SEG_W     = $clog2(SEG_COUNT);

    // Bit k set: axis runs slow in segment k, indexed by letter_e
    localparam logic [SEG_COUNT-1:0] SLOW_MASK_X [SEG_COUNT] = '{
        8'b0001_1111, // A
        8'b0000_0000, // B
        8'b0000_0000, // D
        8'b0000_1100, // N
        8'b0011_1100, // V
        8'b0000_0000, // S
        8'b1100_1100, // X
        8'b0001_1000  // Z
    };

    localparam logic [SEG_COUNT-1:0] SLOW_MASK_Y [SEG_COUNT] = '{
        8'b0000_0000, // A
        8'b0011_1100, // B
        8'b0110_1100, // D
        8'b0000_0000, // N
        8'b0000_0000, // V
        8'b0000_1100, // S
        8'b0000_0000, // X
        8'b0000_0000  // Z
    };

endpackage

/* logic/claw_regs.sv */
`timescale 1ns/10ps

module claw_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  claw_pkg::wb_req_t      wb_req_i,
    output claw_pkg::wb_rsp_t      wb_rsp_o,
    input  logic                   busy_i,
    input  claw_pkg::cmd_e         cmd_i,
    output claw_pkg::motion_ctrl_t ctrl_o
);
    import claw_pkg::*;

    logic       req_valid;
    logic       wr_en;
    logic       ack_q;
    logic [7:0] rd_q;
    logic [7:0] rd_mux;
    logic       start_q;
    cmd_e       cmd_q;
    letter_e    letter_q;
    logic       dir_x_q;
    logic       dir_y_q;
    logic       enable_q;
    logic [2:0] angle_q;

    //////////////////////////////
    // Bus handshake
    //////////////////////////////

    // New transfer only while ack is low, so every cycle pair is one transfer
    assign req_valid = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en     = req_valid && wb_req_i.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_valid;
        end
    end

    always_comb begin
        case (wb_req_i.adr)
            REG_CMD:    rd_mux = {3'b000, letter_q, cmd_q};
            REG_MOTION: rd_mux = {5'b00000, enable_q, dir_y_q, dir_x_q};
            REG_ANGLE:  rd_mux = {5'b00000, angle_q};
            default:    rd_mux = {5'b00000, cmd_i, busy_i}; // Status
        endcase
    end

    // Read data captured on the acking edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q <= 8'h00;
        end else if (req_valid) begin
            rd_q <= rd_mux;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_q;

    //////////////////////////////
    // Control registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q  <= 1'b0;
            cmd_q    <= CMD_IDLE;
            letter_q <= LTR_A;
            dir_x_q  <= 1'b0;
            dir_y_q  <= 1'b0;
            enable_q <= 1'b0;
            angle_q  <= 3'd0;
        end else begin
            start_q <= wr_en && (wb_req_i.adr == REG_CMD);
            if (wr_en) begin
                case (wb_req_i.adr)
                    REG_CMD: begin
                        cmd_q    <= cmd_e'(wb_req_i.dat[1:0]);
                        letter_q <= letter_e'(wb_req_i.dat[4:2]);
                    end
                    REG_MOTION: begin
                        dir_x_q  <= wb_req_i.dat[0];
                        dir_y_q  <= wb_req_i.dat[1];
                        enable_q <= wb_req_i.dat[2];
                    end
                    REG_ANGLE: angle_q <= wb_req_i.dat[2:0];
                    default: ;                        // Status ignores writes
                endcase
            end
        end
    end

    assign ctrl_o = '{start: start_q, cmd: cmd_q, letter: letter_q, dir_x: dir_x_q,
                      dir_y: dir_y_q, enable: enable_q, angle: angle_q};

    // Single cycle ack even with stb held across transfers
    a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        wb_rsp_o.ack |=> !wb_rsp_o.ack);

endmodule

/* logic/trace_profiler.sv */
`timescale 1ns/10ps

module trace_profiler #(
    parameter int TRACE_LEN = 960  // Multiple of SEG_COUNT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  claw_pkg::motion_ctrl_t ctrl_i,
    output claw_pkg::axis_rate_t   rate_o,
    output logic                   busy_o,
    output claw_pkg::cmd_e         cmd_o,
    output logic                   get_o,
    output logic                   write_o
);
    import claw_pkg::*;

    localparam int SEG_LEN = TRACE_LEN / SEG_COUNT;
    localparam int CNT_W   = $clog2(TRACE_LEN);

    cmd_e             state_q;
    letter_e          letter_q;
    logic [CNT_W-1:0] cnt_q;
    logic [SEG_W-1:0] seg;
    logic             accept;
    logic             last;

    //////////////////////////////
    // Command FSM
    //////////////////////////////

    // A running trace blocks any new command
    assign accept = ctrl_i.start && (state_q != CMD_TRACE);
    assign last   = (cnt_q == CNT_W'(TRACE_LEN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= CMD_IDLE;
            letter_q <= LTR_A;
            cnt_q    <= '0;
        end else if (accept) begin
            state_q  <= ctrl_i.cmd;
            letter_q <= ctrl_i.letter;
            cnt_q    <= '0;
        end else if (state_q == CMD_TRACE) begin
            if (last) begin
                state_q <= CMD_IDLE;                  // Trace done
                cnt_q   <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Rate selection
    //////////////////////////////

    // Segment index, equal slices of the trace
    assign seg = SEG_W'(cnt_q / CNT_W'(SEG_LEN));

    always_comb begin
        rate_o = '0;                                  // Fast unless the profile says slow
        if (busy_o) begin
            rate_o.slow_x = SLOW_MASK_X[letter_q][seg];
            rate_o.slow_y = SLOW_MASK_Y[letter_q][seg];
        end
    end

    assign busy_o  = (state_q == CMD_TRACE);
    assign cmd_o   = state_q;
    assign get_o   = (state_q == CMD_GET);
    assign write_o = (state_q == CMD_WRITE);

    // Slow stepping only inside a trace
    a_fast_when_idle: assert property (@(posedge clk) disable iff (rst)
        !busy_o |-> (rate_o == '0));

endmodule

/* logic/step_axis.sv */
`timescale 1ns/10ps

module step_axis #(
    parameter int FAST_PERIOD = 6,
    parameter int SLOW_PERIOD = 12
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       slow_i,
    input  logic       dir_i,
    input  logic       enable_i,
    output logic [3:0] phase_o
);

    localparam int MAX_PERIOD = (SLOW_PERIOD > FAST_PERIOD) ? SLOW_PERIOD : FAST_PERIOD;
    localparam int PER_W      = $clog2(MAX_PERIOD);

    logic [PER_W-1:0] cnt_q;
    logic [PER_W-1:0] period_m1;
    logic             wrap;
    logic [3:0]       phase_q;
    logic [3:0]       phase_next;

    //////////////////////////////
    // Step period counter
    //////////////////////////////

    assign period_m1 = slow_i ? PER_W'(SLOW_PERIOD - 1) : PER_W'(FAST_PERIOD - 1);
    assign wrap      = (cnt_q >= period_m1); // Covers a slow to fast switch mid period

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    //////////////////////////////
    // Full step sequencer
    //////////////////////////////

    always_comb begin
        case (phase_q)
            4'b1100: phase_next = dir_i ? 4'b0110 : 4'b1001;
            4'b0110: phase_next = dir_i ? 4'b0011 : 4'b1100;
            4'b0011: phase_next = dir_i ? 4'b1001 : 4'b0110;
            4'b1001: phase_next = dir_i ? 4'b1100 : 4'b0011;
            default: phase_next = 4'b1100;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= 4'b1100;                       // First entry
        end else if (wrap && enable_i) begin
            phase_q <= phase_next;
        end
    end

    assign phase_o = phase_q;

    a_phase_legal: assert property (@(posedge clk) disable iff (rst)
        phase_o inside {4'b1100, 4'b0110, 4'b0011, 4'b1001});

endmodule

/* logic/servo_pwm.sv */
`timescale 1ns/10ps

module servo_pwm #(
    parameter int PWM_PERIOD = 200,
    parameter int SERVO_BASE = 20,
    parameter int SERVO_STEP = 10
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] angle_i,
    output logic       pwm_o
);

    localparam int CNT_W = $clog2(PWM_PERIOD + 1);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] pulse_w;
    logic [2:0]       angle_q;
    logic             period_end;

    assign period_end = (cnt_q == CNT_W'(PWM_PERIOD - 1));

    // Refresh period, angle sampled for the coming period
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q   <= '0;
            angle_q <= 3'd0;
        end else if (period_end) begin
            cnt_q   <= '0;
            angle_q <= angle_i;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Angle to pulse width, linear in the angle code
    assign pulse_w = CNT_W'(SERVO_BASE) + CNT_W'(SERVO_STEP) * CNT_W'(angle_q);

    assign pwm_o = (cnt_q < pulse_w); // High at the start of each period

endmodule

/* logic/claw_top.sv */
`timescale 1ns/10ps

module claw_top #(
    parameter int FAST_PERIOD = 125_000,
    parameter int SLOW_PERIOD = 250_000,
    parameter int TRACE_LEN   = 674_133_336,
    parameter int PWM_PERIOD  = 1_000_000,  // 10 ms refresh at 100 MHz
    parameter int SERVO_BASE  = 60_000,
    parameter int SERVO_STEP  = 944
) (
    input  logic              clk,
    input  logic              rst,
    input  claw_pkg::wb_req_t wb_req_i,
    output claw_pkg::wb_rsp_t wb_rsp_o,
    output logic [3:0]        phase_x_o,
    output logic [3:0]        phase_y_o,
    output logic              servo_pwm_o,
    output logic              trace_busy_o,
    output logic              get_o,
    output logic              write_o
);
    import claw_pkg::*;

    motion_ctrl_t ctrl;
    axis_rate_t   rate;
    cmd_e         cur_cmd;

    //////////////////////////////
    // Command side
    //////////////////////////////

    claw_regs u_claw_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .busy_i   (trace_busy_o),
        .cmd_i    (cur_cmd),
        .ctrl_o   (ctrl)
    );

    trace_profiler #(.TRACE_LEN(TRACE_LEN)) u_trace_profiler (
        .clk     (clk),
        .rst     (rst),
        .ctrl_i  (ctrl),
        .rate_o  (rate),
        .busy_o  (trace_busy_o),
        .cmd_o   (cur_cmd),
        .get_o   (get_o),
        .write_o (write_o)
    );

    //////////////////////////////
    // Motors
    //////////////////////////////

    step_axis #(.FAST_PERIOD(FAST_PERIOD), .SLOW_PERIOD(SLOW_PERIOD)) u_axis_x (
        .clk      (clk),
        .rst      (rst),
        .slow_i   (rate.slow_x),
        .dir_i    (ctrl.dir_x),
        .enable_i (ctrl.enable),
        .phase_o  (phase_x_o)
    );

    step_axis #(.FAST_PERIOD(FAST_PERIOD), .SLOW_PERIOD(SLOW_PERIOD)) u_axis_y (
        .clk      (clk),
        .rst      (rst),
        .slow_i   (rate.slow_y),
        .dir_i    (ctrl.dir_y),
        .enable_i (ctrl.enable),
        .phase_o  (phase_y_o)
    );

    servo_pwm #(
        .PWM_PERIOD (PWM_PERIOD),
        .SERVO_BASE (SERVO_BASE),
        .SERVO_STEP (SERVO_STEP)
    ) u_servo_pwm (
        .clk     (clk),
        .rst     (rst),
        .angle_i (ctrl.angle),
        .pwm_o   (servo_pwm_o)  // Claw angle (Z)
    );

endmodule

/* tests/claw_checker.sv */
`timescale 1ns/10ps

module claw_checker #(
    parameter int FAST_PERIOD = 6,
    parameter int SLOW_PERIOD = 12,
    parameter int TRACE_LEN   = 960,
    parameter int PWM_PERIOD  = 200,
    parameter int SERVO_BASE  = 20,
    parameter int SERVO_STEP  = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  claw_pkg::wb_req_t wb_req_i,
    input  claw_pkg::wb_rsp_t wb_rsp_i,
    input  logic [3:0]        phase_x_i,
    input  logic [3:0]        phase_y_i,
    input  logic              servo_pwm_i,
    input  logic              trace_busy_i,
    input  logic              get_i,
    input  logic              write_i,
    output int                bus_err_o,
    output int                step_err_o,
    output int                servo_err_o,
    output int                trace_err_o
);
    import claw_pkg::*;

    localparam int SEG_LEN = TRACE_LEN / SEG_COUNT;
    localparam logic [3:0] SEQ [4] = '{4'b1100, 4'b0110, 4'b0011, 4'b1001};

    wb_req_t    held;      // Request waiting for its ack
    logic       ack_due;
    logic       dir_x;
    logic       dir_y;
    logic       enable;
    logic [2:0] angle;
    logic [7:0] cmd_reg;
    logic       cmd_due;   // Profiler takes the command write on the next edge
    cmd_e       cur_cmd;
    cmd_e       old_cmd;
    letter_e    letter;
    int         tcnt;      // Cycles into the running trace
    int         zone;      // Segment index or SEG_COUNT outside a trace
    logic [3:0] last_ph [2];
    int         last_step [2];
    int         last_zone [2];
    logic       run_ok [2]; // Enable held since the last step
    int         quiet [2];  // Enabled cycles without a step
    logic       pwm_q;
    int         high_cnt;
    int         exp_high;
    int         rise_cyc;
    int         cyc;

    //////////////////////////////
    // Reference rules
    //////////////////////////////

    // Neighbour in the full step sequence
    function automatic logic [3:0] step_to(input logic [3:0] ph, input logic dir);
        int idx;
        idx = 0;
        for (int i = 0; i < 4; i++) begin
            if (SEQ[i] == ph) begin
                idx = i;
            end
        end
        return dir ? SEQ[(idx + 1) % 4] : SEQ[(idx + 3) % 4];
    endfunction

    function automatic int step_period(input int ax, input int zn);
        logic [SEG_COUNT-1:0] mask;
        if (zn == SEG_COUNT) begin
            return FAST_PERIOD;
        end
        mask = (ax == 0) ? SLOW_MASK_X[letter] : SLOW_MASK_Y[letter];
        return mask[3'(zn)] ? SLOW_PERIOD : FAST_PERIOD;
    endfunction

    task automatic check_axis(input int ax, input logic [3:0] ph, input logic dir);
        if (!enable) begin
            run_ok[ax] = 1'b0;
        end
        if (ph == last_ph[ax] && enable) begin
            quiet[ax]++;
            if (quiet[ax] == SLOW_PERIOD) begin
                step_err_o++;
                $display("FAIL %0t: axis %0d made no step in %0d enabled cycles",
                         $time, ax, quiet[ax]);
            end
        end else begin
            quiet[ax] = 0;
        end
        if (ph != last_ph[ax]) begin
            if (!enable || ph != step_to(last_ph[ax], dir)) begin
                step_err_o++;
                $display("FAIL %0t: axis %0d phase %b after %b, enable %0b dir %0b",
                         $time, ax, ph, last_ph[ax], enable, dir);
            end
            if (run_ok[ax] && zone == last_zone[ax] &&
                cyc - last_step[ax] != step_period(ax, zone)) begin
                step_err_o++;
                $display("FAIL %0t: axis %0d step interval %0d, expected %0d in zone %0d",
                         $time, ax, cyc - last_step[ax], step_period(ax, zone), zone);
            end
            last_ph[ax]   = ph;
            last_step[ax] = cyc;
            last_zone[ax] = zone;
            run_ok[ax]    = 1'b1;
        end
    endtask

    task automatic check_servo();
        if (!(servo_pwm_i && !pwm_q) && cyc - rise_cyc > PWM_PERIOD) begin
            servo_err_o++;
            $display("FAIL %0t: no PWM period start for %0d cycles",
                     $time, cyc - rise_cyc);
            rise_cyc = cyc;
        end
        if (servo_pwm_i && !pwm_q) begin                 // Period start
            if (rise_cyc >= 0 && cyc - rise_cyc != PWM_PERIOD) begin
                servo_err_o++;
                $display("FAIL %0t: PWM period %0d cycles", $time, cyc - rise_cyc);
            end
            rise_cyc = cyc;
            high_cnt = 1;
            exp_high = SERVO_BASE + SERVO_STEP * int'(angle);
        end else if (servo_pwm_i) begin
            high_cnt++;
        end else if (pwm_q && high_cnt != exp_high) begin
            servo_err_o++;
            $display("FAIL %0t: PWM high for %0d cycles, expected %0d", $time, high_cnt, exp_high);
        end
        pwm_q = servo_pwm_i;
    endtask

    task automatic check_bus();
        logic [7:0] exp_rd;
        if (wb_rsp_i.ack != ack_due) begin
            bus_err_o++;
            $display("FAIL %0t: ack is %0b, expected %0b", $time, wb_rsp_i.ack, ack_due);
        end else if (ack_due && !held.we) begin
            case (held.adr)
                REG_CMD:    exp_rd = {3'b000, cmd_reg[4:0]};
                REG_MOTION: exp_rd = {5'b00000, enable, dir_y, dir_x};
                REG_ANGLE:  exp_rd = {5'b00000, angle};
                default:    exp_rd = {5'b00000, old_cmd, old_cmd == CMD_TRACE};
            endcase
            if (wb_rsp_i.dat != exp_rd) begin
                bus_err_o++;
                $display("FAIL %0t: read of register %0d gave %h, expected %h",
                         $time, held.adr, wb_rsp_i.dat, exp_rd);
            end
        end else if (ack_due) begin
            case (held.adr)
                REG_CMD: begin
                    cmd_due = 1'b1;
                    cmd_reg = held.dat;
                end
                REG_MOTION: begin
                    dir_x  = held.dat[0];
                    dir_y  = held.dat[1];
                    enable = held.dat[2];
                end
                REG_ANGLE: angle = held.dat[2:0];
                default: ;
            endcase
        end
        // Seen with ack low, so acked on the coming edge
        ack_due = wb_req_i.cyc && wb_req_i.stb && !wb_rsp_i.ack;
        if (ack_due) begin
            held = wb_req_i;
        end
    endtask

    //////////////////////////////
    // Sampling at the falling edge
    //////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            {bus_err_o, step_err_o, servo_err_o, trace_err_o} = '0;
            held      = '0;
            ack_due   = 1'b0;
            {dir_x, dir_y, enable, angle} = '0;
            cmd_reg   = '0;
            cmd_due   = 1'b0;
            cur_cmd   = CMD_IDLE;
            old_cmd   = CMD_IDLE;
            letter    = LTR_A;
            tcnt      = 0;
            last_ph   = '{4'b1100, 4'b1100};
            last_step = '{0, 0};
            last_zone = '{SEG_COUNT, SEG_COUNT};
            run_ok    = '{1'b0, 1'b0};
            quiet     = '{0, 0};
            pwm_q     = 1'b0;
            high_cnt  = 0;
            exp_high  = 0;
            rise_cyc  = -1;
            cyc       = 0;
        end else begin
            cyc++;
            zone = (cur_cmd == CMD_TRACE) ? tcnt / SEG_LEN : SEG_COUNT; // Before this edge
            check_axis(0, phase_x_i, dir_x);
            check_axis(1, phase_y_i, dir_y);
            check_servo();
            old_cmd = cur_cmd;
            if (cmd_due && cur_cmd != CMD_TRACE) begin
                cur_cmd = cmd_e'(cmd_reg[1:0]);
                letter  = letter_e'(cmd_reg[4:2]);
                tcnt    = 0;
            end else if (cur_cmd == CMD_TRACE) begin
                tcnt++;
                if (tcnt == TRACE_LEN) begin
                    cur_cmd = CMD_IDLE;
                end
            end
            cmd_due = 1'b0;
            if (trace_busy_i != (cur_cmd == CMD_TRACE) || get_i != (cur_cmd == CMD_GET) ||
                write_i != (cur_cmd == CMD_WRITE)) begin
                trace_err_o++;
                $display("FAIL %0t: busy/get/write %b%b%b, model command %s", $time,
                         trace_busy_i, get_i, write_i, cur_cmd.name());
            end
            check_bus();
        end
    end

endmodule

/* tests/tb_claw.sv */
`timescale 1ns/10ps

module tb_claw;
    import claw_pkg::*;

    localparam int FAST_PERIOD = 6;
    localparam int SLOW_PERIOD = 12;
    localparam int TRACE_LEN   = 960;
    localparam int PWM_PERIOD  = 200;
    localparam int SERVO_BASE  = 20;
    localparam int SERVO_STEP  = 10;
    localparam int MAX_CYCLES  = 8 * TRACE_LEN + 4000;

    logic       clk;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic [3:0] phase_x;
    logic [3:0] phase_y;
    logic       servo_pwm;
    logic       trace_busy;
    logic       claw_get;
    logic       claw_write;
    int         bus_err;
    int         step_err;
    int         servo_err;
    int         trace_err;
    int         cycles = 0;

    claw_top #(
        .FAST_PERIOD (FAST_PERIOD),
        .SLOW_PERIOD (SLOW_PERIOD),
        .TRACE_LEN   (TRACE_LEN),
        .PWM_PERIOD  (PWM_PERIOD),
        .SERVO_BASE  (SERVO_BASE),
        .SERVO_STEP  (SERVO_STEP)
    ) u_claw_top (
        .clk          (clk),
        .rst          (rst),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .phase_x_o    (phase_x),
        .phase_y_o    (phase_y),
        .servo_pwm_o  (servo_pwm),
        .trace_busy_o (trace_busy),
        .get_o        (claw_get),
        .write_o      (claw_write)
    );

    claw_checker #(
        .FAST_PERIOD (FAST_PERIOD),
        .SLOW_PERIOD (SLOW_PERIOD),
        .TRACE_LEN   (TRACE_LEN),
        .PWM_PERIOD  (PWM_PERIOD),
        .SERVO_BASE  (SERVO_BASE),
        .SERVO_STEP  (SERVO_STEP)
    ) u_claw_checker (
        .clk          (clk),
        .rst          (rst),
        .wb_req_i     (wb_req),
        .wb_rsp_i     (wb_rsp),
        .phase_x_i    (phase_x),
        .phase_y_i    (phase_y),
        .servo_pwm_i  (servo_pwm),
        .trace_busy_i (trace_busy),
        .get_i        (claw_get),
        .write_i      (claw_write),
        .bus_err_o    (bus_err),
        .step_err_o   (step_err),
        .servo_err_o  (servo_err),
        .trace_err_o  (trace_err)
    );

    always #10 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic print_counts();
        $display("Errors: bus %0d, step %0d, servo %0d, trace %0d",
                 bus_err, step_err, servo_err, trace_err);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // One Wishbone classic transfer, request held until ack
    task automatic bus_transfer(input logic write_en, input logic [1:0] addr,
                                input logic [7:0] data);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write_en, adr: addr, dat: data};
        @(negedge clk);
        while (!wb_rsp.ack) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        wb_req = '0;
    endtask

    task automatic wait_trace_done();
        while (trace_busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    // Run limit from the length of the test sequence
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        int         seed_ret;
        int         i;
        logic [1:0] addr;
        logic [1:0] code;
        clk    = 1'b0;
        rst    = 1'b1;
        wb_req = '0;
        seed_ret = $urandom(32'hd6942622);
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Register traffic, motors at the fast rate
        for (i = 0; i < 24; i++) begin
            addr = 2'($urandom % 4);
            if ($urandom % 2 == 1) begin
                bus_transfer(1'b1, (addr == REG_CMD) ? REG_MOTION : addr, 8'($urandom));
            end else begin
                bus_transfer(1'b0, addr, 8'h00);
            end
            idle_cycles(int'($urandom % 24));
        end

        // Six traces with commands thrown in while busy
        for (i = 0; i < 6; i++) begin
            bus_transfer(1'b1, REG_MOTION, {5'b00001, 2'($urandom % 4)}); // Enable on
            bus_transfer(1'b1, REG_ANGLE, 8'($urandom));
            bus_transfer(1'b1, REG_CMD, {3'b000, 3'($urandom % 8), CMD_TRACE});
            repeat (4) begin
                idle_cycles(int'($urandom % 150));
                bus_transfer(1'b1, REG_CMD, {3'b000, 3'($urandom % 8), 2'($urandom % 4)});
                bus_transfer(1'b0, REG_STATUS, 8'h00);
            end
            wait_trace_done();
            idle_cycles(int'($urandom % 40));
        end

        // Idle, GET and WRITE commands
        for (i = 0; i < 12; i++) begin
            code = 2'($urandom % 3);
            if (code == 2'd1) begin
                code = CMD_WRITE;
            end
            bus_transfer(1'b1, REG_CMD, {3'b000, 3'($urandom % 8), code});
            idle_cycles(int'($urandom % 20));
            bus_transfer(1'b0, REG_STATUS, 8'h00);
        end
        bus_transfer(1'b0, REG_MOTION, 8'h00);
        bus_transfer(1'b0, REG_ANGLE, 8'h00);
        idle_cycles(2 * PWM_PERIOD);

        print_counts();
        if (bus_err + step_err + servo_err + trace_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/claw_pkg.sv
logic/claw_regs.sv
logic/trace_profiler.sv
logic/step_axis.sv
logic/servo_pwm.sv
logic/claw_top.sv
tests/claw_checker.sv
tests/tb_claw.sv

/* run.sh */
#!/bin/sh
# Build and run the claw controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_claw -f flist.f

out=$(./obj_dir/Vtb_claw)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
